//--- Bender.yml
package:
  name: load_queue

sources:
  - rtl/lq_cfg_pkg.sv
  - rtl/lq_state_pkg.sv
  - rtl/lq_entry_fsm.sv
  - rtl/lq_free_counter.sv
  - rtl/lq_rr_arbiter.sv
  - rtl/lq_entry_store.sv
  - rtl/load_queue.sv
  - target: test
    files:
      - test/load_queue_tb.sv

//--- load_queue.f
rtl/lq_cfg_pkg.sv
rtl/lq_state_pkg.sv
rtl/lq_entry_fsm.sv
rtl/lq_free_counter.sv
rtl/lq_rr_arbiter.sv
rtl/lq_entry_store.sv
rtl/load_queue.sv
test/load_queue_tb.sv

//--- rtl/load_queue.sv
`timescale 1ns/1ps
`default_nettype none

module load_queue (
  input  wire                                                          clock,
  input  wire                                                          reset,
  input  wire                                                          squash,
  input  wire [lq_cfg_pkg::dispatch_lanes-1:0]                         dispatch_valid,
  input  wire [lq_cfg_pkg::dispatch_lanes-1:0][lq_cfg_pkg::rob_idx_w-1:0] dispatch_rob,
  input  wire [lq_cfg_pkg::dispatch_lanes-1:0][lq_cfg_pkg::prf_idx_w-1:0] dispatch_prf,
  input  wire [lq_cfg_pkg::dispatch_lanes-1:0][1:0]                    dispatch_size,
  input  wire [lq_cfg_pkg::dispatch_lanes-1:0]                         dispatch_signed,
  input  wire [lq_cfg_pkg::dispatch_lanes-1:0]                         alu_valid,
  input  wire [lq_cfg_pkg::dispatch_lanes-1:0][lq_cfg_pkg::rob_idx_w-1:0] alu_rob,
  input  wire [lq_cfg_pkg::dispatch_lanes-1:0][lq_cfg_pkg::addr_w-1:0] alu_addr,
  input  wire                                                          cache_busy,
  output logic [lq_cfg_pkg::lq_depth-1:0]                              cache_gnt,
  output logic [lq_cfg_pkg::addr_w-1:0]                                cache_addr,
  input  wire                                                          dcache_hit,
  input  wire [lq_cfg_pkg::data_w-1:0]                                 dcache_data,
  input  wire [lq_cfg_pkg::lq_depth-1:0]                               memory_response,
  input  wire [lq_cfg_pkg::data_w-1:0]                                 memory_data,
  output logic [lq_cfg_pkg::lq_idx_w:0]                                free_space,
  output logic                                                         cdb_valid,
  output logic [lq_cfg_pkg::rob_idx_w-1:0]                             cdb_rob,
  output logic [lq_cfg_pkg::prf_idx_w-1:0]                             cdb_prf,
  output logic [lq_cfg_pkg::data_w-1:0]                                cdb_data
);

  logic [lq_cfg_pkg::lq_depth-1:0] alloc_first;
  logic [lq_cfg_pkg::lq_depth-1:0] alloc_second;
  logic [lq_cfg_pkg::lq_depth-1:0] occupied;
  logic [lq_cfg_pkg::lq_depth-1:0] addr_valid;
  logic [lq_cfg_pkg::lq_depth-1:0] cache_req;
  logic [lq_cfg_pkg::lq_depth-1:0] cdb_req;
  logic [lq_cfg_pkg::lq_depth-1:0] cdb_gnt;

  lq_entry_fsm fsm_i (
    .clock, .reset, .squash, .dispatch_valid, .addr_valid, .cache_busy,
    .cache_gnt, .dcache_hit, .memory_response, .cdb_gnt,
    .alloc_first, .alloc_second, .occupied, .cache_req, .cdb_req
  );

  lq_free_counter counter_i (
    .clock, .reset, .squash, .alloc_first, .alloc_second, .cdb_gnt, .free_space
  );

  // one arbiter per shared resource
  lq_rr_arbiter #(.width(lq_cfg_pkg::lq_depth)) cache_arb_i (
    .clock, .reset, .req(cache_req), .gnt(cache_gnt)
  );

  lq_rr_arbiter #(.width(lq_cfg_pkg::lq_depth)) cdb_arb_i (
    .clock, .reset, .req(cdb_req), .gnt(cdb_gnt)
  );

  lq_entry_store store_i (
    .clock, .reset, .squash, .alloc_first, .alloc_second, .occupied,
    .dispatch_rob, .dispatch_prf, .dispatch_size, .dispatch_signed,
    .alu_valid, .alu_rob, .alu_addr, .cache_gnt, .dcache_hit, .dcache_data,
    .memory_response, .memory_data, .cdb_gnt,
    .addr_valid, .cache_addr, .cdb_rob, .cdb_prf, .cdb_data
  );

  // bus strobe
  assign cdb_valid = |cdb_gnt;

endmodule

`default_nettype wire

//--- rtl/lq_cfg_pkg.sv
`default_nettype none

package lq_cfg_pkg;

  // queue geometry
  localparam int lq_depth = 8;
  localparam int lq_idx_w = 3;
  // loads per cycle, also the number of alu strobe lanes
  localparam int dispatch_lanes = 2;

  // field widths
  localparam int rob_idx_w = 5;
  localparam int prf_idx_w = 6;
  localparam int addr_w = 16;
  localparam int data_w = 32;

  // load size codes
  localparam logic [1:0] size_byte = 2'd0;
  localparam logic [1:0] size_half = 2'd1;
  localparam logic [1:0] size_word = 2'd2;

endpackage

`default_nettype wire

//--- rtl/lq_entry_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module lq_entry_fsm (
  input  wire                                      clock,
  input  wire                                      reset,
  input  wire                                      squash,
  input  wire [lq_cfg_pkg::dispatch_lanes-1:0]     dispatch_valid,
  input  wire [lq_cfg_pkg::lq_depth-1:0]           addr_valid,
  input  wire                                      cache_busy,
  input  wire [lq_cfg_pkg::lq_depth-1:0]           cache_gnt,
  input  wire                                      dcache_hit,
  input  wire [lq_cfg_pkg::lq_depth-1:0]           memory_response,
  input  wire [lq_cfg_pkg::lq_depth-1:0]           cdb_gnt,
  output logic [lq_cfg_pkg::lq_depth-1:0]          alloc_first,
  output logic [lq_cfg_pkg::lq_depth-1:0]          alloc_second,
  output logic [lq_cfg_pkg::lq_depth-1:0]          occupied,
  output logic [lq_cfg_pkg::lq_depth-1:0]          cache_req,
  output logic [lq_cfg_pkg::lq_depth-1:0]          cdb_req
);

  lq_state_pkg::entry_state_t state [lq_cfg_pkg::lq_depth];
  lq_state_pkg::entry_state_t next_state [lq_cfg_pkg::lq_depth];
  logic [lq_cfg_pkg::lq_depth-1:0] free_mask;
  logic [lq_cfg_pkg::lq_depth-1:0] lowest_free;
  logic [lq_cfg_pkg::lq_depth-1:0] second_pool;

  ////////////////////
  // dispatch slot selection

  always_comb begin
    for (int i = 0; i < lq_cfg_pkg::lq_depth; i++) begin
      free_mask[i] = (state[i] == lq_state_pkg::empty);
      occupied[i] = ~free_mask[i];
      cache_req[i] = (state[i] == lq_state_pkg::wait_cache) && !cache_busy;
      cdb_req[i] = (state[i] == lq_state_pkg::wait_cdb);
    end
  end

  // isolate lowest set bit
  assign lowest_free = free_mask & (~free_mask + 1'b1);
  assign alloc_first = dispatch_valid[0] ? lowest_free : '0;
  assign second_pool = free_mask & ~alloc_first;

  // lane one goes to the top free slot
  always_comb begin
    alloc_second = '0;
    for (int i = 0; i < lq_cfg_pkg::lq_depth; i++) begin
      if (dispatch_valid[1] && second_pool[i]) begin
        alloc_second = '0;
        alloc_second[i] = 1'b1;
      end
    end
  end

  ////////////////////
  // per-entry state machines

  always_comb begin
    for (int i = 0; i < lq_cfg_pkg::lq_depth; i++) begin
      next_state[i] = state[i];
      case (state[i])
        lq_state_pkg::empty:
          if (alloc_first[i] || alloc_second[i]) next_state[i] = lq_state_pkg::wait_addr;
        lq_state_pkg::wait_addr:
          if (addr_valid[i]) next_state[i] = lq_state_pkg::wait_cache;
        lq_state_pkg::wait_cache:
          if (cache_gnt[i]) begin
            next_state[i] = dcache_hit ? lq_state_pkg::wait_cdb : lq_state_pkg::wait_memory;
          end
        lq_state_pkg::wait_memory:
          if (memory_response[i]) next_state[i] = lq_state_pkg::wait_cdb;
        lq_state_pkg::wait_cdb:
          if (cdb_gnt[i]) next_state[i] = lq_state_pkg::empty;
        default: next_state[i] = lq_state_pkg::empty;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < lq_cfg_pkg::lq_depth; i++) begin
      if (reset || squash) begin
        state[i] <= lq_state_pkg::empty;
      end else begin
        state[i] <= next_state[i];
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/lq_entry_store.sv
`timescale 1ns/1ps
`default_nettype none

module lq_entry_store (
  input  wire                                                          clock,
  input  wire                                                          reset,
  input  wire                                                          squash,
  input  wire [lq_cfg_pkg::lq_depth-1:0]                               alloc_first,
  input  wire [lq_cfg_pkg::lq_depth-1:0]                               alloc_second,
  input  wire [lq_cfg_pkg::lq_depth-1:0]                               occupied,
  input  wire [lq_cfg_pkg::dispatch_lanes-1:0][lq_cfg_pkg::rob_idx_w-1:0] dispatch_rob,
  input  wire [lq_cfg_pkg::dispatch_lanes-1:0][lq_cfg_pkg::prf_idx_w-1:0] dispatch_prf,
  input  wire [lq_cfg_pkg::dispatch_lanes-1:0][1:0]                    dispatch_size,
  input  wire [lq_cfg_pkg::dispatch_lanes-1:0]                         dispatch_signed,
  input  wire [lq_cfg_pkg::dispatch_lanes-1:0]                         alu_valid,
  input  wire [lq_cfg_pkg::dispatch_lanes-1:0][lq_cfg_pkg::rob_idx_w-1:0] alu_rob,
  input  wire [lq_cfg_pkg::dispatch_lanes-1:0][lq_cfg_pkg::addr_w-1:0] alu_addr,
  input  wire [lq_cfg_pkg::lq_depth-1:0]                               cache_gnt,
  input  wire                                                          dcache_hit,
  input  wire [lq_cfg_pkg::data_w-1:0]                                 dcache_data,
  input  wire [lq_cfg_pkg::lq_depth-1:0]                               memory_response,
  input  wire [lq_cfg_pkg::data_w-1:0]                                 memory_data,
  input  wire [lq_cfg_pkg::lq_depth-1:0]                               cdb_gnt,
  output logic [lq_cfg_pkg::lq_depth-1:0]                              addr_valid,
  output logic [lq_cfg_pkg::addr_w-1:0]                                cache_addr,
  output logic [lq_cfg_pkg::rob_idx_w-1:0]                             cdb_rob,
  output logic [lq_cfg_pkg::prf_idx_w-1:0]                             cdb_prf,
  output logic [lq_cfg_pkg::data_w-1:0]                                cdb_data
);

  logic [lq_cfg_pkg::rob_idx_w-1:0] rob_q [lq_cfg_pkg::lq_depth];
  logic [lq_cfg_pkg::prf_idx_w-1:0] prf_q [lq_cfg_pkg::lq_depth];
  logic [1:0] size_q [lq_cfg_pkg::lq_depth];
  logic [lq_cfg_pkg::lq_depth-1:0] signed_q;
  logic [lq_cfg_pkg::addr_w-1:0] addr_q [lq_cfg_pkg::lq_depth];
  logic [lq_cfg_pkg::data_w-1:0] word_q [lq_cfg_pkg::lq_depth];

  logic [lq_cfg_pkg::lq_depth-1:0] addr_match;
  logic [lq_cfg_pkg::addr_w-1:0] match_addr [lq_cfg_pkg::lq_depth];

  logic [1:0] sel_addr;
  logic [lq_cfg_pkg::data_w-1:0] sel_word;
  logic [1:0] sel_size;
  logic sel_signed;
  logic [lq_cfg_pkg::data_w-1:0] shifted;

  ////////////////////
  // alu address match

  // lane 0 wins if both lanes hit one entry
  always_comb begin
    for (int i = 0; i < lq_cfg_pkg::lq_depth; i++) begin
      addr_match[i] = 1'b0;
      match_addr[i] = '0;
      for (int l = lq_cfg_pkg::dispatch_lanes - 1; l >= 0; l--) begin
        if (alu_valid[l] && occupied[i] && !addr_valid[i] && alu_rob[l] == rob_q[i]) begin
          addr_match[i] = 1'b1;
          match_addr[i] = alu_addr[l];
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset || squash) begin
      addr_valid <= '0;
    end else begin
      for (int i = 0; i < lq_cfg_pkg::lq_depth; i++) begin
        if (alloc_first[i] || alloc_second[i] || cdb_gnt[i]) begin
          addr_valid[i] <= 1'b0;
        end else if (addr_match[i]) begin
          addr_valid[i] <= 1'b1;
        end
      end
    end
  end

  ////////////////////
  // payload fields

  always_ff @(posedge clock) begin
    for (int i = 0; i < lq_cfg_pkg::lq_depth; i++) begin
      if (alloc_first[i]) begin
        rob_q[i] <= dispatch_rob[0];
        prf_q[i] <= dispatch_prf[0];
        size_q[i] <= dispatch_size[0];
        signed_q[i] <= dispatch_signed[0];
      end else if (alloc_second[i]) begin
        rob_q[i] <= dispatch_rob[1];
        prf_q[i] <= dispatch_prf[1];
        size_q[i] <= dispatch_size[1];
        signed_q[i] <= dispatch_signed[1];
      end
      if (addr_match[i]) addr_q[i] <= match_addr[i];
      // raw word from cache hit or memory fill
      if (cache_gnt[i] && dcache_hit) begin
        word_q[i] <= dcache_data;
      end else if (memory_response[i]) begin
        word_q[i] <= memory_data;
      end
    end
  end

  ////////////////////
  // cache and bus muxes

  always_comb begin
    cache_addr = '0;
    cdb_rob = '0;
    cdb_prf = '0;
    sel_addr = '0;
    sel_word = '0;
    sel_size = '0;
    sel_signed = 1'b0;
    for (int i = 0; i < lq_cfg_pkg::lq_depth; i++) begin
      if (cache_gnt[i]) cache_addr = addr_q[i];
      if (cdb_gnt[i]) begin
        cdb_rob = rob_q[i];
        cdb_prf = prf_q[i];
        sel_addr = addr_q[i][1:0];
        sel_word = word_q[i];
        sel_size = size_q[i];
        sel_signed = signed_q[i];
      end
    end
  end

  // byte lane select then sign or zero extension
  assign shifted = sel_word >> {sel_addr, 3'b000};

  always_comb begin
    case (sel_size)
      lq_cfg_pkg::size_byte:
        cdb_data = {{(lq_cfg_pkg::data_w-8){sel_signed & shifted[7]}}, shifted[7:0]};
      lq_cfg_pkg::size_half:
        cdb_data = {{(lq_cfg_pkg::data_w-16){sel_signed & shifted[15]}}, shifted[15:0]};
      default:
        cdb_data = shifted;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/lq_free_counter.sv
`timescale 1ns/1ps
`default_nettype none

module lq_free_counter (
  input  wire                                   clock,
  input  wire                                   reset,
  input  wire                                   squash,
  input  wire [lq_cfg_pkg::lq_depth-1:0]        alloc_first,
  input  wire [lq_cfg_pkg::lq_depth-1:0]        alloc_second,
  input  wire [lq_cfg_pkg::lq_depth-1:0]        cdb_gnt,
  output logic [lq_cfg_pkg::lq_idx_w:0]         free_space
);

  logic [lq_cfg_pkg::lq_idx_w:0] taken;
  logic [lq_cfg_pkg::lq_idx_w:0] released;

  // at most one slot per lane, one slot freed by the bus
  always_comb begin
    taken = {{lq_cfg_pkg::lq_idx_w{1'b0}}, |alloc_first};
    taken = taken + {{lq_cfg_pkg::lq_idx_w{1'b0}}, |alloc_second};
    released = {{lq_cfg_pkg::lq_idx_w{1'b0}}, |cdb_gnt};
  end

  always_ff @(posedge clock) begin
    if (reset || squash) begin
      free_space <= (lq_cfg_pkg::lq_idx_w + 1)'(lq_cfg_pkg::lq_depth);
    end else begin
      free_space <= free_space - taken + released;
    end
  end

endmodule

`default_nettype wire

//--- rtl/lq_rr_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module lq_rr_arbiter #(
  parameter int width = lq_cfg_pkg::lq_depth
) (
  input  wire               clock,
  input  wire               reset,
  input  wire [width-1:0]   req,
  output logic [width-1:0]  gnt
);

  // bits strictly above the last grant
  logic [width-1:0] mask;
  logic [width-1:0] masked_req;
  logic [width-1:0] masked_gnt;
  logic [width-1:0] plain_gnt;

  assign masked_req = req & mask;

  // lowest set bit of each request set
  assign masked_gnt = masked_req & (~masked_req + {{(width-1){1'b0}}, 1'b1});
  assign plain_gnt = req & (~req + {{(width-1){1'b0}}, 1'b1});

  // wrap to the bottom when nothing sits above the pointer
  assign gnt = (|masked_req) ? masked_gnt : plain_gnt;

  ////////////////////
  // pointer update

  always_ff @(posedge clock) begin
    if (reset) begin
      // empty mask so the first pick is the lowest requester
      mask <= '0;
    end else if (|gnt) begin
      mask <= ~(gnt | (gnt - {{(width-1){1'b0}}, 1'b1}));
    end
  end

endmodule

`default_nettype wire

//--- rtl/lq_state_pkg.sv
`default_nettype none

package lq_state_pkg;

  // life of one load entry
  typedef enum logic [2:0] {
    empty,
    wait_addr,
    wait_cache,
    wait_memory,
    wait_cdb
  } entry_state_t;

endpackage

`default_nettype wire

//--- test/load_queue_tb.sv
`timescale 1ns/1ps
`default_nettype none

module load_queue_tb;

  localparam int clock_period = 8;
  localparam int reset_cycles = 16;
  localparam int n_rows = 16;
  localparam int cycles_per_row = 200;
  localparam int depth = lq_cfg_pkg::lq_depth;
  localparam int lanes = lq_cfg_pkg::dispatch_lanes;
  localparam int rob_w = lq_cfg_pkg::rob_idx_w;
  localparam int prf_w = lq_cfg_pkg::prf_idx_w;
  localparam int addr_w = lq_cfg_pkg::addr_w;
  localparam int data_w = lq_cfg_pkg::data_w;

  typedef struct packed {
    logic [rob_w-1:0] rob;
    logic [prf_w-1:0] prf;
    logic [1:0] size;
    logic sign;
    logic [addr_w-1:0] addr;
    logic hit;
    logic [data_w-1:0] word;
    logic [data_w-1:0] expected;
  } load_row_t;

  logic clock = 1'b0;
  logic reset;
  logic squash;
  logic [lanes-1:0] dispatch_valid;
  logic [lanes-1:0][rob_w-1:0] dispatch_rob;
  logic [lanes-1:0][prf_w-1:0] dispatch_prf;
  logic [lanes-1:0][1:0] dispatch_size;
  logic [lanes-1:0] dispatch_signed;
  logic [lanes-1:0] alu_valid;
  logic [lanes-1:0][rob_w-1:0] alu_rob;
  logic [lanes-1:0][addr_w-1:0] alu_addr;
  logic cache_busy;
  logic [depth-1:0] cache_gnt;
  logic [addr_w-1:0] cache_addr;
  logic dcache_hit;
  logic [data_w-1:0] dcache_data;
  logic [depth-1:0] memory_response;
  logic [data_w-1:0] memory_data;
  logic [lq_cfg_pkg::lq_idx_w:0] free_space;
  logic cdb_valid;
  logic [rob_w-1:0] cdb_rob;
  logic [prf_w-1:0] cdb_prf;
  logic [data_w-1:0] cdb_data;

  load_row_t rows [n_rows];
  int error_count;
  int tests_run;
  int tests_failed;
  // model of the cache arbiter pointer
  int cache_last;

  load_queue dut_i (
    .clock, .reset, .squash, .dispatch_valid, .dispatch_rob, .dispatch_prf,
    .dispatch_size, .dispatch_signed, .alu_valid, .alu_rob, .alu_addr,
    .cache_busy, .cache_gnt, .cache_addr, .dcache_hit, .dcache_data,
    .memory_response, .memory_data, .free_space, .cdb_valid, .cdb_rob,
    .cdb_prf, .cdb_data
  );

  always #(clock_period / 2) clock = ~clock;

  initial begin
    #(clock_period * (n_rows * cycles_per_row + reset_cycles));
    $display("timeout: the run did not finish in %0d cycles",
             n_rows * cycles_per_row + reset_cycles);
    $display("CHECKS FAILED");
    $finish;
  end

  ////////////////////
  // reference models

  // shift to the addressed byte, keep by size, then extend
  function automatic logic [data_w-1:0] extract_load(input logic [data_w-1:0] word,
      input logic [1:0] offset, input logic [1:0] size, input logic sign);
    logic [data_w-1:0] value;
    logic [data_w-1:0] keep;
    int top;
    value = word >> (8 * offset);
    if (size == lq_cfg_pkg::size_byte) begin
      keep = 32'h0000_00ff;
      top = 7;
    end else if (size == lq_cfg_pkg::size_half) begin
      keep = 32'h0000_ffff;
      top = 15;
    end else begin
      keep = '1;
      top = data_w - 1;
    end
    value = value & keep;
    if (sign && value[top]) value = value | ~keep;
    return value;
  endfunction

  // first requester above the last grant, wrapping around
  function automatic int next_grant(input logic [depth-1:0] req, input int last);
    int idx;
    for (int k = 1; k <= depth; k++) begin
      idx = (last + k) % depth;
      if (req[idx]) return idx;
    end
    return -1;
  endfunction

  function automatic logic [depth-1:0] onehot(input int idx);
    logic [depth-1:0] v;
    v = '0;
    v[idx] = 1'b1;
    return v;
  endfunction

  ////////////////////
  // reporting and drive helpers

  task automatic flag_mismatch(input string name, input logic [31:0] expected,
      input logic [31:0] actual);
    $display("ERROR at %0t: %s expected 0x%0h got 0x%0h", $time, name, expected, actual);
    error_count++;
  endtask

  task automatic note_failure(input string text);
    $display("failure at %0t: %s", $time, text);
    error_count++;
  endtask

  task automatic close_test(input string label, input int start_errors);
    tests_run++;
    if (error_count == start_errors) begin
      $display("test %s: ok", label);
    end else begin
      $display("test %s: %0d errors", label, error_count - start_errors);
      tests_failed++;
    end
  endtask

  task automatic check_cdb(input string label, input logic [rob_w-1:0] rob,
      input logic [prf_w-1:0] prf, input logic [data_w-1:0] data);
    if (cdb_valid !== 1'b1) begin
      note_failure($sformatf("%s: cdb_valid missing when the result was due", label));
    end else begin
      if (cdb_rob !== rob) flag_mismatch("cdb_rob", rob, cdb_rob);
      if (cdb_prf !== prf) flag_mismatch("cdb_prf", prf, cdb_prf);
      if (cdb_data !== data) flag_mismatch("cdb_data", data, cdb_data);
    end
  endtask

  task automatic drive_dispatch(input int lane, input logic [rob_w-1:0] rob,
      input logic [prf_w-1:0] prf, input logic [1:0] size, input logic sign);
    dispatch_rob[lane] = rob;
    dispatch_prf[lane] = prf;
    dispatch_size[lane] = size;
    dispatch_signed[lane] = sign;
  endtask

  task automatic drive_alu(input int lane, input logic [rob_w-1:0] rob,
      input logic [addr_w-1:0] addr);
    alu_rob[lane] = rob;
    alu_addr[lane] = addr;
  endtask

  ////////////////////
  // table and tests

  task automatic build_table();
    logic [1:0] offset;
    logic [31:0] r;
    for (int i = 0; i < n_rows; i++) begin
      offset = 2'd0;
      rows[i].sign = 1'b0;
      rows[i].size = lq_cfg_pkg::size_word;
      if (i < 8) begin
        rows[i].size = lq_cfg_pkg::size_byte;
        offset = i[1:0];
        rows[i].sign = (i >= 4);
      end else if (i < 12) begin
        rows[i].size = lq_cfg_pkg::size_half;
        offset = i[0] ? 2'd2 : 2'd0;
        rows[i].sign = (i >= 10);
      end else if (i == 13) begin
        rows[i].size = lq_cfg_pkg::size_byte;
        offset = 2'd3;
        rows[i].sign = 1'b1;
      end else if (i == 14) begin
        rows[i].size = lq_cfg_pkg::size_half;
        offset = 2'd2;
        rows[i].sign = 1'b1;
      end
      r = $urandom;
      rows[i].rob = r[rob_w-1:0];
      rows[i].prf = 6'(i + 20);
      rows[i].word = $urandom;
      // odd rows get negative bytes
      if (i % 2 == 1) rows[i].word = rows[i].word | 32'h8080_8080;
      r = $urandom;
      rows[i].addr = {r[addr_w-1:2], offset};
      rows[i].hit = (i <= 12);
      rows[i].expected = extract_load(rows[i].word, offset, rows[i].size, rows[i].sign);
    end
  endtask

  task automatic check_after_reset();
    int start_errors;
    start_errors = error_count;
    #2;
    if (free_space !== 4'(depth)) flag_mismatch("free_space", depth, free_space);
    if (cdb_valid !== 1'b0) flag_mismatch("cdb_valid", 0, cdb_valid);
    if (cache_gnt !== '0) flag_mismatch("cache_gnt", 0, cache_gnt);
    close_test("after reset", start_errors);
  endtask

  task automatic run_row(input int i);
    int start_errors;
    string label;
    start_errors = error_count;
    label = $sformatf("row %0d size %0d offset %0d signed %0b %s", i, rows[i].size,
                      rows[i].addr[1:0], rows[i].sign, rows[i].hit ? "hit" : "miss");
    @(negedge clock);
    dispatch_valid = 2'b01;
    drive_dispatch(0, rows[i].rob, rows[i].prf, rows[i].size, rows[i].sign);
    @(negedge clock);
    dispatch_valid = '0;
    alu_valid = 2'b01;
    drive_alu(0, rows[i].rob, rows[i].addr);
    dcache_hit = rows[i].hit;
    // a miss must not pick up the cache word
    dcache_data = rows[i].hit ? rows[i].word : ~rows[i].word;
    @(negedge clock);
    alu_valid = '0;
    @(negedge clock);
    #2;
    if (cache_gnt !== onehot(0)) flag_mismatch("cache_gnt", onehot(0), cache_gnt);
    if (cache_addr !== rows[i].addr) flag_mismatch("cache_addr", rows[i].addr, cache_addr);
    cache_last = 0;
    if (!rows[i].hit) begin
      repeat (4) begin
        @(negedge clock);
        #2;
        if (cdb_valid !== 1'b0) note_failure($sformatf("%s: cdb_valid before memory", label));
      end
      @(negedge clock);
      memory_response = onehot(0);
      memory_data = rows[i].word;
    end
    @(negedge clock);
    memory_response = '0;
    #2;
    check_cdb(label, rows[i].rob, rows[i].prf, rows[i].expected);
    @(negedge clock);
    #2;
    if (free_space !== 4'(depth)) flag_mismatch("free_space", depth, free_space);
    close_test(label, start_errors);
  endtask

  task automatic dual_dispatch();
    int start_errors;
    int load_of_entry [depth];
    logic [data_w-1:0] words [4];
    logic [addr_w-1:0] addrs [4];
    logic [1:0] sizes [4];
    logic [3:0] signs;
    logic [depth-1:0] pending;
    int granted;
    int prev;
    int ld;
    start_errors = error_count;
    // lane 0 takes the lowest free entry, lane 1 the highest
    load_of_entry[0] = 0;
    load_of_entry[7] = 1;
    load_of_entry[1] = 2;
    load_of_entry[6] = 3;
    // lanes carry different sizes so a crossed lane shows in the data
    sizes[0] = lq_cfg_pkg::size_word;
    sizes[1] = lq_cfg_pkg::size_byte;
    sizes[2] = lq_cfg_pkg::size_half;
    sizes[3] = lq_cfg_pkg::size_byte;
    signs = 4'b0110;
    for (int k = 0; k < 4; k++) begin
      words[k] = $urandom | 32'h8080_8080;
      // offsets 0 to 3 in load order
      addrs[k] = 16'h0400 + 16'(k * 5);
    end
    @(negedge clock);
    cache_busy = 1'b1;
    dispatch_valid = 2'b11;
    drive_dispatch(0, 5'd20, 6'd40, sizes[0], signs[0]);
    drive_dispatch(1, 5'd21, 6'd41, sizes[1], signs[1]);
    @(negedge clock);
    drive_dispatch(0, 5'd22, 6'd42, sizes[2], signs[2]);
    drive_dispatch(1, 5'd23, 6'd43, sizes[3], signs[3]);
    alu_valid = 2'b11;
    drive_alu(0, 5'd20, addrs[0]);
    drive_alu(1, 5'd21, addrs[1]);
    #2;
    if (free_space !== 4'(depth - 2)) flag_mismatch("free_space", depth - 2, free_space);
    @(negedge clock);
    dispatch_valid = '0;
    drive_alu(0, 5'd22, addrs[2]);
    drive_alu(1, 5'd23, addrs[3]);
    #2;
    if (free_space !== 4'(depth - 4)) flag_mismatch("free_space", depth - 4, free_space);
    repeat (3) begin
      @(negedge clock);
      alu_valid = '0;
      #2;
      if (cache_gnt !== '0) flag_mismatch("cache_gnt", 0, cache_gnt);
    end
    // all four wait for the cache, released together
    pending = onehot(0) | onehot(1) | onehot(6) | onehot(7);
    prev = -1;
    for (int k = 0; k < 5; k++) begin
      @(negedge clock);
      cache_busy = 1'b0;
      dcache_hit = 1'b1;
      granted = (pending != '0) ? next_grant(pending, cache_last) : -1;
      if (granted >= 0) dcache_data = words[load_of_entry[granted]];
      #2;
      if (granted >= 0) begin
        if (cache_gnt !== onehot(granted)) flag_mismatch("cache_gnt", onehot(granted), cache_gnt);
        if (cache_addr !== addrs[load_of_entry[granted]]) begin
          flag_mismatch("cache_addr", addrs[load_of_entry[granted]], cache_addr);
        end
        pending[granted] = 1'b0;
        cache_last = granted;
      end else if (cache_gnt !== '0) begin
        flag_mismatch("cache_gnt", 0, cache_gnt);
      end
      if (prev >= 0) begin
        ld = load_of_entry[prev];
        check_cdb("dual dispatch", 5'd20 + 5'(ld), 6'd40 + 6'(ld),
                  extract_load(words[ld], addrs[ld][1:0], sizes[ld], signs[ld]));
      end
      prev = granted;
    end
    @(negedge clock);
    #2;
    if (free_space !== 4'(depth)) flag_mismatch("free_space", depth, free_space);
    if (cdb_valid !== 1'b0) flag_mismatch("cdb_valid", 0, cdb_valid);
    close_test("dual dispatch", start_errors);
  endtask

  task automatic busy_hold();
    int start_errors;
    logic [data_w-1:0] word;
    start_errors = error_count;
    word = $urandom | 32'h0000_8000;
    @(negedge clock);
    cache_busy = 1'b1;
    dispatch_valid = 2'b01;
    drive_dispatch(0, 5'd9, 6'd33, lq_cfg_pkg::size_byte, 1'b1);
    @(negedge clock);
    dispatch_valid = '0;
    alu_valid = 2'b01;
    drive_alu(0, 5'd9, 16'h1235);
    dcache_hit = 1'b1;
    dcache_data = word;
    repeat (5) begin
      @(negedge clock);
      alu_valid = '0;
      #2;
      if (cache_gnt !== '0) flag_mismatch("cache_gnt", 0, cache_gnt);
    end
    @(negedge clock);
    cache_busy = 1'b0;
    #2;
    if (cache_gnt !== onehot(next_grant(onehot(0), cache_last))) begin
      flag_mismatch("cache_gnt", onehot(0), cache_gnt);
    end
    if (cache_addr !== 16'h1235) flag_mismatch("cache_addr", 16'h1235, cache_addr);
    cache_last = 0;
    @(negedge clock);
    #2;
    check_cdb("cache busy", 5'd9, 6'd33,
              extract_load(word, 2'd1, lq_cfg_pkg::size_byte, 1'b1));
    @(negedge clock);
    #2;
    if (free_space !== 4'(depth)) flag_mismatch("free_space", depth, free_space);
    close_test("cache busy", start_errors);
  endtask

  task automatic squash_flush();
    int start_errors;
    start_errors = error_count;
    @(negedge clock);
    cache_busy = 1'b1;
    dispatch_valid = 2'b11;
    drive_dispatch(0, 5'd3, 6'd12, lq_cfg_pkg::size_word, 1'b0);
    drive_dispatch(1, 5'd4, 6'd13, lq_cfg_pkg::size_half, 1'b1);
    @(negedge clock);
    dispatch_valid = '0;
    alu_valid = 2'b01;
    drive_alu(0, 5'd3, 16'h2000);
    @(negedge clock);
    alu_valid = '0;
    #2;
    if (free_space !== 4'(depth - 2)) flag_mismatch("free_space", depth - 2, free_space);
    @(negedge clock);
    squash = 1'b1;
    @(negedge clock);
    squash = 1'b0;
    #2;
    if (free_space !== 4'(depth)) flag_mismatch("free_space", depth, free_space);
    // stale indices must find nothing to match
    @(negedge clock);
    cache_busy = 1'b0;
    alu_valid = 2'b11;
    drive_alu(0, 5'd3, 16'h2000);
    drive_alu(1, 5'd4, 16'h2002);
    repeat (6) begin
      @(negedge clock);
      alu_valid = '0;
      #2;
      if (cdb_valid !== 1'b0) note_failure("squash: cdb_valid from a squashed load");
      if (cache_gnt !== '0) flag_mismatch("cache_gnt", 0, cache_gnt);
    end
    if (free_space !== 4'(depth)) flag_mismatch("free_space", depth, free_space);
    close_test("squash", start_errors);
  endtask

  initial begin
    void'($urandom(32'hd9025572));
    error_count = 0;
    tests_run = 0;
    tests_failed = 0;
    cache_last = depth - 1;
    reset = 1'b1;
    squash = 1'b0;
    dispatch_valid = '0;
    dispatch_rob = '0;
    dispatch_prf = '0;
    dispatch_size = '0;
    dispatch_signed = '0;
    alu_valid = '0;
    alu_rob = '0;
    alu_addr = '0;
    cache_busy = 1'b0;
    dcache_hit = 1'b0;
    dcache_data = '0;
    memory_response = '0;
    memory_data = '0;
    build_table();
    repeat (reset_cycles) @(negedge clock);
    reset = 1'b0;
    check_after_reset();
    for (int i = 0; i < n_rows; i++) run_row(i);
    dual_dispatch();
    busy_hold();
    squash_flush();
    $display("summary: %0d tests, %0d passed, %0d with errors, %0d errors in all",
             tests_run, tests_run - tests_failed, tests_failed, error_count);
    if (error_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
